/* Bender.yml */
package:
  name: instr_realign

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/fetch_pkg.sv
      - common/instr_pkg.sv
      - instr_realign/fetch_decode.sv
      - instr_realign/carry_store.sv
      - instr_realign/slot_combine.sv
      - design/instr_realign.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/instr_realign_assertions.sv
      - test/tb_instr_realign.sv

/* common/fetch_pkg.sv */
// ----------------------------------------------------------------------
// types for the incoming fetch word and the classification of its parcels
// ----------------------------------------------------------------------
`include "realign_defines.svh"

package fetch_pkg;

    // ------------------------------------------------------------------
    // raw fetch word
    // ------------------------------------------------------------------

    // valid strobe, fetch address and data as they arrive from the cache
    typedef struct packed {
        logic                         valid;
        logic [`RA_VLEN-1:0]          addr;
        logic [`RA_FETCH_WIDTH-1:0]   data;
    } fetch_word_t;

    // ------------------------------------------------------------------
    // classified parcels
    // ------------------------------------------------------------------

    // one compressed bit per parcel, the halfword start flag and the
    // two slot addresses derived from the fetch address
    typedef struct packed {
        logic [`RA_INSTR_PER_FETCH-1:0] compressed;
        logic                           mid_entry;
        logic [`RA_VLEN-1:0]            base_addr;
        logic [`RA_VLEN-1:0]            upper_addr;
    } parcel_info_t;

endpackage

/* common/instr_pkg.sv */
// ----------------------------------------------------------------------
// types for the emitted instruction slots and the held upper parcel
// ----------------------------------------------------------------------
`include "realign_defines.svh"

package instr_pkg;

    // an emitted instruction is always 32 bits, compressed ones are
    // zero-extended into it
    localparam int unsigned INSTR_WIDTH = 32;

    // ------------------------------------------------------------------
    // output slot
    // ------------------------------------------------------------------

    typedef struct packed {
        logic                     valid;
        logic [`RA_VLEN-1:0]      addr;
        logic [INSTR_WIDTH-1:0]   instr;
    } instr_slot_t;

    // ------------------------------------------------------------------
    // held parcel of a straddling instruction
    // ------------------------------------------------------------------

    // pending says the parcel waits for its upper half, load says the
    // state is taken over at the next edge
    typedef struct packed {
        logic                         pending;
        logic                         load;
        logic [`RA_PARCEL_WIDTH-1:0]  parcel;
        logic [`RA_VLEN-1:0]          addr;
    } carry_t;

endpackage

/* common/realign_defines.svh */
// ----------------------------------------------------------------------
// widths shared by the instruction re-aligner and its packages
// include this before any package or module that sizes fetch signals
// ----------------------------------------------------------------------
`ifndef REALIGN_DEFINES_SVH
`define REALIGN_DEFINES_SVH

// ----------------------------------------------------------------------
// address and data widths
// ----------------------------------------------------------------------

// virtual address width of the fetch stage
`define RA_VLEN 32

// one fetch word as delivered by the instruction cache
`define RA_FETCH_WIDTH 32

// ----------------------------------------------------------------------
// parcel geometry
// ----------------------------------------------------------------------

// a parcel is the 16-bit unit of the compressed extension
`define RA_PARCEL_WIDTH 16

// a 32-bit word carries two parcels and so at most two instructions
`define RA_INSTR_PER_FETCH 2

`endif

/* design/instr_realign.sv */
// ----------------------------------------------------------------------
// instruction re-aligner of the fetch stage, turns 32-bit fetch words
// into up to two aligned instructions with zero cycles of latency
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "realign_defines.svh"

module instr_realign (
    input  logic                                                clk_i,
    input  logic                                                rst_ni,
    input  logic                                                flush_i,
    input  logic                                                valid_i,
    input  logic [`RA_VLEN-1:0]                                 address_i,
    input  logic [`RA_FETCH_WIDTH-1:0]                          data_i,
    // slot 0 completes an instruction held from the last word
    output logic                                                serving_unaligned_o,
    output instr_pkg::instr_slot_t [`RA_INSTR_PER_FETCH-1:0]    slots_o
);

    fetch_pkg::fetch_word_t  fetch;
    fetch_pkg::parcel_info_t info;
    instr_pkg::carry_t       held;
    instr_pkg::carry_t       carry_next;

    assign fetch = '{valid: valid_i, addr: address_i, data: data_i};

    fetch_decode u_fetch_decode (
        .fetch_i (fetch),
        .info_o  (info)
    );

    carry_store u_carry_store (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .carry_next_i (carry_next),
        .held_o       (held)
    );

    slot_combine u_slot_combine (
        .fetch_i      (fetch),
        .info_i       (info),
        .held_i       (held),
        .slots_o      (slots_o),
        .carry_next_o (carry_next)
    );

    assign serving_unaligned_o = held.pending;

endmodule

/* instr_realign.f */
+incdir+common
common/fetch_pkg.sv
common/instr_pkg.sv
instr_realign/fetch_decode.sv
instr_realign/carry_store.sv
instr_realign/slot_combine.sv
design/instr_realign.sv
test/instr_realign_assertions.sv
test/tb_instr_realign.sv

/* instr_realign/carry_store.sv */
// ----------------------------------------------------------------------
// state of the re-aligner, holds the lower half of a straddling
// 32-bit instruction until the next fetch word delivers the rest
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "realign_defines.svh"

module carry_store (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  instr_pkg::carry_t carry_next_i,
    output instr_pkg::carry_t held_o
);

    logic                        pending_q;
    logic [`RA_PARCEL_WIDTH-1:0] parcel_q;
    logic [`RA_VLEN-1:0]         addr_q;

    // ------------------------------------------------------------------
    // control flags
    // ------------------------------------------------------------------

    // a flush throws away whatever parcel is waiting, it wins over load
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else begin
            if (flush_i) begin
                pending_q <= 1'b0;
            end else if (carry_next_i.load) begin
                pending_q <= carry_next_i.pending;
            end
        end
    end

    // ------------------------------------------------------------------
    // payload
    // ------------------------------------------------------------------

    // parcel and address only matter while pending is set
    always_ff @(posedge clk_i) begin
        if (carry_next_i.load) begin
            parcel_q <= carry_next_i.parcel;
            addr_q   <= carry_next_i.addr;
        end
    end

    // the held copy never asks for a load of its own
    assign held_o = '{pending: pending_q, load: 1'b0, parcel: parcel_q, addr: addr_q};

endmodule

/* instr_realign/fetch_decode.sv */
// ----------------------------------------------------------------------
// parcel classifier of the re-aligner, purely combinational
// tags compressed parcels and derives the slot addresses of a fetch word
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "realign_defines.svh"

module fetch_decode (
    input  fetch_pkg::fetch_word_t  fetch_i,
    output fetch_pkg::parcel_info_t info_o
);

    // ------------------------------------------------------------------
    // compressed detection
    // ------------------------------------------------------------------

    // a parcel starts a 32-bit instruction only when both low bits are 1
    // and anything else belongs to the compressed set
    logic [`RA_INSTR_PER_FETCH-1:0] is_compressed;

    for (genvar i = 0; i < `RA_INSTR_PER_FETCH; i++) begin : gen_parcel
        assign is_compressed[i] = ~&fetch_i.data[i*`RA_PARCEL_WIDTH +: 2];
    end

    // ------------------------------------------------------------------
    // address forming
    // ------------------------------------------------------------------

    logic [`RA_VLEN-1:0] word_addr;

    // the cache hands out word-aligned blocks so the low two bits are
    // dropped to get the block base
    assign word_addr = {fetch_i.addr[`RA_VLEN-1:2], 2'b00};

    always_comb begin
        info_o.compressed = is_compressed;

        // bit 1 set means a jump landed on the upper parcel of the word
        info_o.mid_entry  = fetch_i.addr[1];

        info_o.base_addr  = word_addr;

        // the upper parcel sits one halfword above the base
        info_o.upper_addr = {word_addr[`RA_VLEN-1:2], 2'b10};
    end

endmodule

/* instr_realign/slot_combine.sv */
// ----------------------------------------------------------------------
// slot logic of the re-aligner, merges the held parcel with the new
// fetch word into up to two instructions and picks the next held state
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "realign_defines.svh"

module slot_combine (
    input  fetch_pkg::fetch_word_t                              fetch_i,
    input  fetch_pkg::parcel_info_t                             info_i,
    input  instr_pkg::carry_t                                   held_i,
    output instr_pkg::instr_slot_t [`RA_INSTR_PER_FETCH-1:0]    slots_o,
    output instr_pkg::carry_t                                   carry_next_o
);

    localparam int unsigned PadWidth = instr_pkg::INSTR_WIDTH - `RA_PARCEL_WIDTH;

    logic [`RA_PARCEL_WIDTH-1:0] p0;
    logic [`RA_PARCEL_WIDTH-1:0] p1;

    assign p0 = fetch_i.data[`RA_PARCEL_WIDTH-1:0];
    assign p1 = fetch_i.data[2*`RA_PARCEL_WIDTH-1:`RA_PARCEL_WIDTH];

    always_comb begin
        // ----------------------------------------------------------------
        // defaults
        // ----------------------------------------------------------------

        // state only moves on a valid fetch
        carry_next_o.load    = fetch_i.valid;
        carry_next_o.pending = held_i.pending;
        carry_next_o.parcel  = p1;
        carry_next_o.addr    = info_i.upper_addr;

        // slot 0 either completes the held instruction or takes the word
        slots_o[0].valid = fetch_i.valid;
        if (held_i.pending) begin
            slots_o[0].instr = {p0, held_i.parcel};
            slots_o[0].addr  = held_i.addr;
        end else begin
            slots_o[0].instr = fetch_i.data;
            slots_o[0].addr  = fetch_i.addr;
        end

        slots_o[1].valid = 1'b0;
        slots_o[1].instr = '0;
        slots_o[1].addr  = info_i.upper_addr;

        // ----------------------------------------------------------------
        // upper parcel
        // ----------------------------------------------------------------

        // once the lower parcel is used up by slot 0 the upper parcel
        // starts a new instruction of its own
        if (info_i.compressed[0] || held_i.pending) begin
            if (info_i.compressed[1]) begin
                // whole compressed instruction, nothing left over
                carry_next_o.pending = 1'b0;
                slots_o[1].valid     = fetch_i.valid;
                if (fetch_i.valid) begin
                    slots_o[1].instr = {{PadWidth{1'b0}}, p1};
                end
            end else begin
                // lower half of a 32-bit instruction, wait for the rest
                carry_next_o.pending = 1'b1;
            end
        end

        // ----------------------------------------------------------------
        // halfword entry
        // ----------------------------------------------------------------

        // a jump into the middle of the word only leaves the upper parcel
        if (fetch_i.valid && info_i.mid_entry) begin
            if (!info_i.compressed[0]) begin
                // half an instruction, nothing can go out this cycle
                slots_o[0].valid     = 1'b0;
                slots_o[1].valid     = 1'b0;
                slots_o[1].instr     = '0;
                carry_next_o.pending = 1'b1;
                carry_next_o.parcel  = p0;
            end else begin
                slots_o[1].valid = 1'b0;
                slots_o[1].instr = '0;
            end
        end
    end

endmodule

/* test/instr_realign_assertions.sv */
// ----------------------------------------------------------------------
// protocol assertions of the re-aligner, bound to its top level
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "realign_defines.svh"

module instr_realign_assertions (
    input logic                                             clk_i,
    input logic                                             rst_ni,
    input logic                                             flush_i,
    input logic                                             valid_i,
    input logic                                             serving_unaligned_o,
    input instr_pkg::instr_slot_t [`RA_INSTR_PER_FETCH-1:0] slots_o
);

    // the upper parcel can only go out together with the lower one
    slot1_needs_slot0: assert property (@(posedge clk_i) disable iff (!rst_ni)
        slots_o[1].valid |-> slots_o[0].valid)
    else begin
        $error("slot 1 valid without slot 0");
        tb_instr_realign.assert_errors++;
    end

    // slot 1 only ever carries a zero-extended compressed parcel
    slot1_upper_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
        slots_o[1].valid |-> (slots_o[1].instr[31:16] == '0 &&
                              slots_o[1].instr[1:0] != 2'b11))
    else begin
        $error("slot 1 instruction is not a zero-extended compressed parcel");
        tb_instr_realign.assert_errors++;
    end

    // the held parcel is dropped by a flush at the following edge
    flush_clears_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $past(flush_i) |-> !serving_unaligned_o)
    else begin
        $error("unaligned flag still set after a flush edge");
        tb_instr_realign.assert_errors++;
    end

    // nothing is held when the re-aligner comes out of reset
    reset_clears_pending: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> !serving_unaligned_o)
    else begin
        $error("unaligned flag set after reset");
        tb_instr_realign.assert_errors++;
    end

    // an idle fetch never produces an instruction
    idle_no_slots: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !valid_i |-> !(slots_o[0].valid || slots_o[1].valid))
    else begin
        $error("slot valid while the fetch is idle");
        tb_instr_realign.assert_errors++;
    end

endmodule

/* test/realign_vectors.txt */
// columns: test id, flush, valid, address, data, slot0 valid/addr/instr,
// slot1 valid/addr/instr, expected unaligned flag; all hex, one cycle per line
// aligned full instructions
1_0_1_00001000_00500093_1_00001000_00500093_0_00000000_00000000_0
1_0_1_00001004_00a00113_1_00001004_00a00113_0_00000000_00000000_0
1_0_1_00001008_002081b3_1_00001008_002081b3_0_00000000_00000000_0
// two compressed parcels per word
2_0_1_00002000_45014081_1_00002000_45014081_1_00002002_00004501_0
2_0_1_00002004_80820001_1_00002004_80820001_1_00002006_00008082_0
// compressed parcel then one straddling instruction
3_0_1_00003000_05134581_1_00003000_05134581_0_00000000_00000000_0
3_0_1_00003004_45050015_1_00003002_00150513_1_00003006_00004505_1
3_0_1_00003008_00500093_1_00003008_00500093_0_00000000_00000000_0
// chain of straddling instructions
4_0_1_00004000_05934601_1_00004000_05934601_0_00000000_00000000_0
4_0_1_00004004_06130005_1_00004002_00050593_0_00000000_00000000_1
4_0_1_00004008_06930006_1_00004006_00060613_0_00000000_00000000_1
4_0_1_0000400c_46850007_1_0000400a_00070693_1_0000400e_00004685_1
4_0_1_00004010_00500093_1_00004010_00500093_0_00000000_00000000_0
// fetch starting at a halfword address
5_0_1_00005002_12340713_0_00000000_00000000_0_00000000_00000000_0
5_0_1_00005004_47050010_1_00005002_00100713_1_00005006_00004705_1
5_0_1_0000500a_47894501_1_0000500a_47894501_0_00000000_00000000_0
5_0_1_0000500c_00500093_1_0000500c_00500093_0_00000000_00000000_0
// idle cycle and flush while a parcel is held
6_0_1_00006000_07934581_1_00006000_07934581_0_00000000_00000000_0
6_0_0_00000000_00000000_0_00000000_00000000_0_00000000_00000000_1
6_1_0_00000000_00000000_0_00000000_00000000_0_00000000_00000000_1
6_0_1_00007000_00a00113_1_00007000_00a00113_0_00000000_00000000_0

/* test/tb_instr_realign.sv */
// ----------------------------------------------------------------------
// testbench of the re-aligner, replays the vector file cycle by cycle
// and compares both slots and the unaligned flag against it
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "realign_defines.svh"

module tb_instr_realign;

    // one vector line, every field padded to whole hex digits
    typedef struct packed {
        logic [3:0]                  test_id;
        logic [3:0]                  flush;
        logic [3:0]                  valid;
        logic [`RA_VLEN-1:0]         addr;
        logic [`RA_FETCH_WIDTH-1:0]  data;
        logic [3:0]                  s0_valid;
        logic [`RA_VLEN-1:0]         s0_addr;
        logic [31:0]                 s0_instr;
        logic [3:0]                  s1_valid;
        logic [`RA_VLEN-1:0]         s1_addr;
        logic [31:0]                 s1_instr;
        logic [3:0]                  serving;
    } vector_t;

    localparam int NUM_VECTORS = 21;
    localparam int RESET_CYCLES = 2;
    // every vector takes one cycle, the rest is slack for reset and the end
    localparam int CYCLE_LIMIT = NUM_VECTORS + RESET_CYCLES + 20;

    logic                                             clk_i;
    logic                                             rst_ni;
    logic                                             flush_i;
    logic                                             valid_i;
    logic [`RA_VLEN-1:0]                              address_i;
    logic [`RA_FETCH_WIDTH-1:0]                       data_i;
    logic                                             serving_unaligned_o;
    instr_pkg::instr_slot_t [`RA_INSTR_PER_FETCH-1:0] slots_o;

    logic [$bits(vector_t)-1:0] vector_mem [0:NUM_VECTORS-1];

    int    errors;
    int    assert_errors;
    int    tests_run;
    int    tests_failed;
    int    cycle_count;
    string cur_name;

    instr_realign u_instr_realign (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .valid_i             (valid_i),
        .address_i           (address_i),
        .data_i              (data_i),
        .serving_unaligned_o (serving_unaligned_o),
        .slots_o             (slots_o)
    );

    bind instr_realign instr_realign_assertions u_realign_assertions (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .valid_i             (valid_i),
        .serving_unaligned_o (serving_unaligned_o),
        .slots_o             (slots_o)
    );

    // 40 ns period
    always #20 clk_i = ~clk_i;

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    return "aligned_full";
            4'd2:    return "two_compressed";
            4'd3:    return "straddle_once";
            4'd4:    return "straddle_chain";
            4'd5:    return "halfword_entry";
            4'd6:    return "flush_pending";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare_value(input string field, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED test %s, %s: expected %h, actual %h",
                     cur_name, field, expected, actual);
            errors++;
        end
    endtask

    task automatic close_test(input int errors_at_start);
        tests_run++;
        if (errors > errors_at_start) begin
            tests_failed++;
            $display("test %-16s failed with %0d errors", cur_name, errors - errors_at_start);
        end else begin
            $display("test %-16s passed", cur_name);
        end
    endtask

    // ------------------------------------------------------------------
    // run limit
    // ------------------------------------------------------------------

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // stimulus and checks
    // ------------------------------------------------------------------

    initial begin
        vector_t vec;
        vector_t next_vec;
        int      errors_at_start;
        clk_i         = 1'b0;
        rst_ni        = 1'b0;
        flush_i       = 1'b0;
        valid_i       = 1'b0;
        address_i     = '0;
        data_i        = '0;
        errors        = 0;
        assert_errors = 0;
        tests_run     = 0;
        tests_failed  = 0;
        cycle_count   = 0;
        errors_at_start = 0;
        $readmemh("test/realign_vectors.txt", vector_mem);
        repeat (RESET_CYCLES) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            @(posedge clk_i);
            #2;
            vec       = vector_mem[i];
            cur_name  = test_name(vec.test_id);
            flush_i   = vec.flush[0];
            valid_i   = vec.valid[0];
            address_i = vec.addr;
            data_i    = vec.data;
            // outputs are combinational, so they settle well before the edge
            #36;
            compare_value("slot0 valid", 32'(vec.s0_valid[0]), 32'(slots_o[0].valid));
            if (vec.s0_valid[0]) begin
                compare_value("slot0 addr", vec.s0_addr, slots_o[0].addr);
                compare_value("slot0 instr", vec.s0_instr, slots_o[0].instr);
            end
            compare_value("slot1 valid", 32'(vec.s1_valid[0]), 32'(slots_o[1].valid));
            if (vec.s1_valid[0]) begin
                compare_value("slot1 addr", vec.s1_addr, slots_o[1].addr);
                compare_value("slot1 instr", vec.s1_instr, slots_o[1].instr);
            end else begin
                // an empty slot 1 still names the upper halfword and carries no instruction
                compare_value("slot1 addr", (vec.addr & ~32'h3) + 32'h2, slots_o[1].addr);
                compare_value("slot1 instr", 32'h0, slots_o[1].instr);
            end
            compare_value("serving", 32'(vec.serving[0]), 32'(serving_unaligned_o));
            // a test ends where the next line carries another test id
            if (i == NUM_VECTORS - 1) begin
                close_test(errors_at_start);
            end else begin
                next_vec = vector_mem[i+1];
                if (next_vec.test_id != vec.test_id) begin
                    close_test(errors_at_start);
                    errors_at_start = errors;
                end
            end
        end
        @(posedge clk_i);
        $display("tests run %0d, tests failed %0d, check errors %0d, assertion errors %0d",
                 tests_run, tests_failed, errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $finish;
        end
    end

endmodule
